// ==== verilog.f ====
+incdir+sim
common/rv_pkg.sv
verilog/rv_regfile.sv
verilog/rv_fetch.sv
decode/rv_decode.sv
execute/rv_alu.sv
execute/rv_execute.sv
verilog/rv_mem_wb.sv
verilog/rv_core.sv
sim/rv_core_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := rv_core_tb
FILELIST := verilog.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/rv_model.svh ====
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

localparam int            PROG_WORDS = 64;
localparam rv_pkg::insn_t ECALL      = 32'h0000_0073;

// One expected retirement, with the branch outcome kept alongside
typedef struct packed {
  rv_pkg::xlen_t    pc;
  rv_pkg::insn_t    insn;
  rv_pkg::reg_idx_t rd;
  rv_pkg::xlen_t    wdata;
  logic             we;
  logic             halt;
  logic             taken;
} expect_t;

rv_pkg::insn_t prog [PROG_WORDS];
expect_t       expected [$];

// Everything past the program reads as ecall
function automatic rv_pkg::insn_t imem_word(rv_pkg::xlen_t addr);
  if (addr >= 32'(4 * PROG_WORDS)) begin
    return ECALL;
  end
  return prog[addr[7:2]];
endfunction

task automatic gen_program();
  logic [2:0]       kind;
  logic [2:0]       f3;
  logic [6:0]       f7;
  logic             alt;
  logic [12:0]      off;
  rv_pkg::reg_idx_t rd;
  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  for (int i = 0; i < PROG_WORDS - 1; i++) begin
    kind = 3'(rand_bits(3));
    // Only x0..x7 so that dependences are dense
    rd  = 5'(rand_bits(3));
    rs1 = 5'(rand_bits(3));
    rs2 = 5'(rand_bits(3));
    f3  = 3'(rand_bits(3));
    alt = 1'(rand_bits(1));
    f7  = 7'd0;
    if (kind <= 3'd2) begin
      if (f3 == 3'd1 || f3 == 3'd5) begin
        if (f3 == 3'd5 && alt) begin
          f7 = 7'b0100000;
        end
        prog[i] = {f7, 5'(rand_bits(5)), rs1, f3, rd, rv_pkg::OP_REG_IMM};
      end else begin
        prog[i] = {12'(rand_bits(12)), rs1, f3, rd, rv_pkg::OP_REG_IMM};
      end
    end else if (kind <= 3'd4) begin
      if ((f3 == 3'd0 || f3 == 3'd5) && alt) begin
        f7 = 7'b0100000;
      end
      prog[i] = {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG_REG};
    end else if (kind == 3'd5) begin
      prog[i] = {20'(rand_bits(20)), rd, rv_pkg::OP_LUI};
    end else begin
      // funct3 values 2 and 3 are not branches, fold them onto beq and bne
      if (f3[2:1] == 2'b01) begin
        f3 = {2'b00, f3[0]};
      end
      off = {8'd0, 3'(rand_bits(2)) + 3'd1, 2'b00};
      prog[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OP_BRANCH};
    end
  end
  prog[PROG_WORDS - 1] = ECALL;
endtask

// Sequential ISA model, one record per executed instruction
task automatic run_model();
  rv_pkg::xlen_t regs [32];
  rv_pkg::xlen_t pc;
  rv_pkg::xlen_t next_pc;
  rv_pkg::xlen_t a;
  rv_pkg::xlen_t b;
  rv_pkg::insn_t insn;
  logic [2:0]    f3;
  logic          cond;
  expect_t       e;
  for (int i = 0; i < 32; i++) begin
    regs[i] = '0;
  end
  expected.delete();
  pc = '0;
  e  = '0;
  while (!e.halt) begin
    insn    = imem_word(pc);
    f3      = insn[14:12];
    a       = regs[insn[19:15]];
    b       = regs[insn[24:20]];
    next_pc = pc + 32'd4;
    e       = '0;
    e.pc    = pc;
    e.insn  = insn;
    case (insn[6:0])
      rv_pkg::OP_REG_IMM, rv_pkg::OP_REG_REG: begin
        if (insn[6:0] == rv_pkg::OP_REG_IMM) begin
          b = {{20{insn[31]}}, insn[31:20]};
        end
        e.rd = insn[11:7];
        e.we = 1'b1;
        case (f3)
          3'd0: e.wdata = (insn[5] && insn[30]) ? a - b : a + b;
          3'd1: e.wdata = a << b[4:0];
          3'd2: e.wdata = {31'b0, $signed(a) < $signed(b)};
          3'd3: e.wdata = {31'b0, a < b};
          3'd4: e.wdata = a ^ b;
          3'd5: e.wdata = insn[30] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
          3'd6: e.wdata = a | b;
          default: e.wdata = a & b;
        endcase
      end
      rv_pkg::OP_LUI: begin
        e.rd    = insn[11:7];
        e.we    = 1'b1;
        e.wdata = {insn[31:12], 12'b0};
      end
      rv_pkg::OP_BRANCH: begin
        case (f3)
          3'd0: cond = a == b;
          3'd1: cond = a != b;
          3'd4: cond = $signed(a) < $signed(b);
          3'd5: cond = $signed(a) >= $signed(b);
          3'd6: cond = a < b;
          default: cond = a >= b;
        endcase
        if (cond) begin
          e.taken = 1'b1;
          next_pc = pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
        end
      end
      default: e.halt = 1'b1;
    endcase
    if (e.we && e.rd != '0) begin
      regs[e.rd] = e.wdata;
    end
    expected.push_back(e);
    pc = next_pc;
  end
endtask

`endif

// ==== sim/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

  localparam int TIMEOUT_CYCLES = 2000;

  logic            clk;
  logic            rst;
  rv_pkg::insn_t   insn_i;
  rv_pkg::xlen_t   pc_o;
  logic            halt_o;
  rv_pkg::result_t trace_o;

  logic [31:0] lfsr_state;
  int          errors;
  int          checks;

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_step();
    logic out;
    out        = lfsr_state[0];
    lfsr_state = (lfsr_state >> 1) ^ (out ? 32'h8020_0003 : 32'h0);
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  `include "rv_model.svh"

  rv_core #(
    .RESET_PC ('0)
  ) UUT (
    .clk     (clk),
    .rst     (rst),
    .insn_i  (insn_i),
    .pc_o    (pc_o),
    .halt_o  (halt_o),
    .trace_o (trace_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Instruction memory answers the PC shortly after each edge
  initial begin
    insn_i = '0;
    forever begin
      @(posedge clk);
      #1;
      insn_i = imem_word(pc_o);
    end
  end

  task automatic compare_word(string name, logic [31:0] got, logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic check_reset_window();
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      compare_word("trace_o.status", 32'(trace_o.status), 32'(rv_pkg::CYCLE_RESET));
      compare_word("trace_o.we", 32'(trace_o.we), 32'd0);
      compare_word("halt_o", 32'(halt_o), 32'd0);
    end
  endtask

  task automatic check_retirement();
    expect_t e;
    int      idx;
    int      bubbles;
    int      cycles;
    logic    halted;
    idx     = 0;
    bubbles = 0;
    cycles  = 0;
    halted  = 1'b0;
    while (!halted && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
      if (bubbles > 0) begin
        // Squashed slots behind a taken branch
        compare_word("trace_o.status", 32'(trace_o.status), 32'(rv_pkg::CYCLE_TAKEN_BRANCH));
        compare_word("trace_o.we", 32'(trace_o.we), 32'd0);
        compare_word("trace_o.pc", trace_o.pc, 32'd0);
        compare_word("trace_o.insn", trace_o.insn, 32'd0);
        compare_word("trace_o.halt", 32'(trace_o.halt), 32'd0);
        compare_word("halt_o", 32'(halt_o), 32'd0);
        bubbles--;
      end else if (trace_o.status != rv_pkg::CYCLE_NO_STALL) begin
        errors++;
        $display("Cycle status %0d at %0t where an instruction should retire",
                 trace_o.status, $time);
      end else if (idx >= expected.size()) begin
        errors++;
        $display("Core retired more instructions than the model executed");
        halted = 1'b1;
      end else begin
        e = expected[idx];
        idx++;
        compare_word("trace_o.pc", trace_o.pc, e.pc);
        compare_word("trace_o.insn", trace_o.insn, e.insn);
        compare_word("trace_o.rd", 32'(trace_o.rd), 32'(e.rd));
        compare_word("trace_o.we", 32'(trace_o.we), 32'(e.we));
        if (e.we) begin
          compare_word("trace_o.wdata", trace_o.wdata, e.wdata);
        end
        compare_word("trace_o.halt", 32'(trace_o.halt), 32'(e.halt));
        compare_word("halt_o", 32'(halt_o), 32'(e.halt));
        if (e.taken) begin
          bubbles = 2;
        end
        halted = halt_o;
      end
    end
    if (!halted) begin
      errors++;
      $display("Timed out after %0d cycles waiting for halt_o", cycles);
    end
  endtask

  initial begin
    rst        = 1'b1;
    errors     = 0;
    checks     = 0;
    lfsr_state = 32'h5ae91151;
    gen_program();
    run_model();
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    check_reset_window();
    check_retirement();
    $display("Checks: %0d, errors: %0d, instructions modeled: %0d",
             checks, errors, expected.size());
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== verilog/rv_core.sv ====
`timescale 1ns/1ps

module rv_core #(
  parameter rv_pkg::xlen_t RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst,
  input  rv_pkg::insn_t   insn_i,
  output rv_pkg::xlen_t   pc_o,
  output logic            halt_o,
  output rv_pkg::result_t trace_o
);

  rv_pkg::redirect_t redirect;
  rv_pkg::fd_t       fd;
  rv_pkg::dx_t       dx;
  rv_pkg::result_t   xm;
  rv_pkg::result_t   mem;
  rv_pkg::result_t   wb;

  rv_fetch #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clk        (clk),
    .rst        (rst),
    .insn_i     (insn_i),
    .redirect_i (redirect),
    .pc_o       (pc_o),
    .fd_o       (fd)
  );

  rv_decode u_decode (
    .clk        (clk),
    .rst        (rst),
    .fd_i       (fd),
    .redirect_i (redirect),
    .wb_i       (wb),
    .dx_o       (dx)
  );

  rv_execute u_execute (
    .clk        (clk),
    .rst        (rst),
    .dx_i       (dx),
    .mem_i      (mem),
    .wb_i       (wb),
    .redirect_o (redirect),
    .xm_o       (xm)
  );

  rv_mem_wb u_mem_wb (
    .clk   (clk),
    .rst   (rst),
    .xm_i  (xm),
    .mem_o (mem),
    .wb_o  (wb)
  );

  // Retirement trace straight from writeback
  assign trace_o = wb;
  assign halt_o  = wb.halt;

endmodule

// ==== verilog/rv_mem_wb.sv ====
`timescale 1ns/1ps

module rv_mem_wb (
  input  logic            clk,
  input  logic            rst,
  input  rv_pkg::result_t xm_i,
  output rv_pkg::result_t mem_o,
  output rv_pkg::result_t wb_o
);

  localparam rv_pkg::result_t RESET_REC = '{
    pc:     '0,
    insn:   '0,
    rd:     '0,
    wdata:  '0,
    we:     1'b0,
    halt:   1'b0,
    status: rv_pkg::CYCLE_RESET
  };

  rv_pkg::result_t mem_q;
  rv_pkg::result_t wb_q;

  // Memory stage has no data access and only carries the record along
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_q <= RESET_REC;
      wb_q  <= RESET_REC;
    end else begin
      mem_q <= xm_i;
      wb_q  <= mem_q;
    end
  end

  assign mem_o = mem_q;
  assign wb_o  = wb_q;

endmodule

// ==== execute/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::dx_t       dx_i,
  input  rv_pkg::result_t   mem_i,
  input  rv_pkg::result_t   wb_i,
  output rv_pkg::redirect_t redirect_o,
  output rv_pkg::result_t   xm_o
);

  rv_pkg::xlen_t op_a;
  rv_pkg::xlen_t rs2_val;
  rv_pkg::xlen_t op_b;
  rv_pkg::xlen_t alu_result;
  logic          br_cond;

  // Memory stage is younger, so it wins over writeback
  assign op_a = rv_pkg::bypass(mem_i, dx_i.rs1,
                               rv_pkg::bypass(wb_i, dx_i.rs1, dx_i.rs1_val));
  assign rs2_val = rv_pkg::bypass(mem_i, dx_i.rs2,
                                  rv_pkg::bypass(wb_i, dx_i.rs2, dx_i.rs2_val));
  assign op_b = dx_i.use_imm ? dx_i.imm : rs2_val;

  rv_alu u_alu (
    .op_i     (dx_i.alu_op),
    .a_i      (op_a),
    .b_i      (op_b),
    .imm_i    (dx_i.imm),
    .result_o (alu_result)
  );

  // Branch compares always use both registers
  always_comb begin
    case (dx_i.br_op)
      rv_pkg::BEQ:  br_cond = op_a == rs2_val;
      rv_pkg::BNE:  br_cond = op_a != rs2_val;
      rv_pkg::BLT:  br_cond = $signed(op_a) < $signed(rs2_val);
      rv_pkg::BGE:  br_cond = $signed(op_a) >= $signed(rs2_val);
      rv_pkg::BLTU: br_cond = op_a < rs2_val;
      rv_pkg::BGEU: br_cond = op_a >= rs2_val;
      default:      br_cond = 1'b0;
    endcase
  end

  assign redirect_o.taken  = dx_i.is_branch && br_cond;
  assign redirect_o.target = dx_i.pc + dx_i.imm;

  // Record handed to the memory stage register
  always_comb begin
    xm_o.pc     = dx_i.pc;
    xm_o.insn   = dx_i.insn;
    xm_o.rd     = dx_i.rd;
    xm_o.wdata  = alu_result;
    xm_o.we     = dx_i.writes_rd;
    xm_o.halt   = dx_i.is_ecall;
    xm_o.status = dx_i.status;
  end

  // Bubbles never redirect
  a_redirect_valid: assert property (@(posedge clk) disable iff (rst)
    redirect_o.taken |-> dx_i.status == rv_pkg::CYCLE_NO_STALL);

  // Decode has to hand over a squashed slot right after a redirect
  a_redirect_squash: assert property (@(posedge clk) disable iff (rst)
    redirect_o.taken |=> dx_i.status == rv_pkg::CYCLE_TAKEN_BRANCH);

endmodule

// ==== execute/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::alu_op_e op_i,
  input  rv_pkg::xlen_t   a_i,
  input  rv_pkg::xlen_t   b_i,
  input  rv_pkg::xlen_t   imm_i,
  output rv_pkg::xlen_t   result_o
);

  logic          is_sub;
  rv_pkg::xlen_t sum;
  logic [4:0]    shamt;
  logic          lt_s;
  logic          lt_u;

  // One adder for add and sub, two's complement via carry in
  assign is_sub = op_i == rv_pkg::SUB;
  assign sum    = a_i + (is_sub ? ~b_i : b_i) + {31'b0, is_sub};

  assign shamt = b_i[4:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;

  always_comb begin
    case (op_i)
      rv_pkg::ADD,
      rv_pkg::SUB:  result_o = sum;
      rv_pkg::SLL:  result_o = a_i << shamt;
      rv_pkg::SLT:  result_o = {31'b0, lt_s};
      rv_pkg::SLTU: result_o = {31'b0, lt_u};
      rv_pkg::XOR:  result_o = a_i ^ b_i;
      rv_pkg::SRL:  result_o = a_i >> shamt;
      rv_pkg::SRA:  result_o = rv_pkg::xlen_t'($signed(a_i) >>> shamt);
      rv_pkg::OR:   result_o = a_i | b_i;
      rv_pkg::AND:  result_o = a_i & b_i;
      // U immediate arrives already shifted into place
      rv_pkg::LUI:  result_o = imm_i;
      default:      result_o = '0;
    endcase
  end

endmodule

// ==== decode/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::fd_t       fd_i,
  input  rv_pkg::redirect_t redirect_i,
  input  rv_pkg::result_t   wb_i,
  output rv_pkg::dx_t       dx_o
);

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::reg_idx_t rd;
  rv_pkg::xlen_t    imm_i;
  rv_pkg::xlen_t    imm_b;
  rv_pkg::xlen_t    imm_u;
  rv_pkg::xlen_t    rf_rdata1;
  rv_pkg::xlen_t    rf_rdata2;
  logic             valid;
  rv_pkg::dx_t      dec;
  rv_pkg::dx_t      dx_q;

  assign {funct7, rs2, rs1, funct3, rd, opcode} = fd_i.insn;
  assign valid = fd_i.status == rv_pkg::CYCLE_NO_STALL;

  assign imm_i = {{20{fd_i.insn[31]}}, fd_i.insn[31:20]};
  assign imm_b = {{20{fd_i.insn[31]}}, fd_i.insn[7], fd_i.insn[30:25], fd_i.insn[11:8], 1'b0};
  assign imm_u = {fd_i.insn[31:12], 12'b0};

  // Writeback port doubles as the register write
  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .we_i     (wb_i.we),
    .waddr_i  (wb_i.rd),
    .wdata_i  (wb_i.wdata),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (rf_rdata1),
    .rdata2_o (rf_rdata2)
  );

  always_comb begin
    dec         = '0;
    dec.pc      = fd_i.pc;
    dec.insn    = fd_i.insn;
    dec.status  = fd_i.status;
    dec.rs1     = rs1;
    dec.rs2     = rs2;
    // Register written this cycle is not yet visible in the array
    dec.rs1_val = rv_pkg::bypass(wb_i, rs1, rf_rdata1);
    dec.rs2_val = rv_pkg::bypass(wb_i, rs2, rf_rdata2);
    dec.imm     = imm_i;
    dec.alu_op  = rv_pkg::ADD;
    dec.br_op   = rv_pkg::br_op_e'(funct3);
    case (opcode)
      rv_pkg::OP_REG_IMM, rv_pkg::OP_REG_REG: begin
        dec.rd        = rd;
        dec.writes_rd = valid;
        dec.use_imm   = opcode == rv_pkg::OP_REG_IMM;
        case (funct3)
          3'b000: begin
            if (opcode == rv_pkg::OP_REG_REG && funct7[5]) begin
              dec.alu_op = rv_pkg::SUB;
            end else begin
              dec.alu_op = rv_pkg::ADD;
            end
          end
          3'b001: dec.alu_op = rv_pkg::SLL;
          3'b010: dec.alu_op = rv_pkg::SLT;
          3'b011: dec.alu_op = rv_pkg::SLTU;
          3'b100: dec.alu_op = rv_pkg::XOR;
          3'b101: dec.alu_op = funct7[5] ? rv_pkg::SRA : rv_pkg::SRL;
          3'b110: dec.alu_op = rv_pkg::OR;
          default: dec.alu_op = rv_pkg::AND;
        endcase
      end
      rv_pkg::OP_LUI: begin
        dec.rd        = rd;
        dec.writes_rd = valid;
        dec.use_imm   = 1'b1;
        dec.imm       = imm_u;
        dec.alu_op    = rv_pkg::LUI;
      end
      rv_pkg::OP_BRANCH: begin
        dec.imm       = imm_b;
        dec.is_branch = valid;
      end
      rv_pkg::OP_SYSTEM: begin
        dec.is_ecall = valid && fd_i.insn[31:7] == 25'd0;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dx_q        <= '0;
      dx_q.status <= rv_pkg::CYCLE_RESET;
    end else if (redirect_i.taken) begin
      dx_q        <= '0;
      dx_q.status <= rv_pkg::CYCLE_TAKEN_BRANCH;
    end else begin
      dx_q <= dec;
    end
  end

  assign dx_o = dx_q;

endmodule

// ==== verilog/rv_fetch.sv ====
`timescale 1ns/1ps

module rv_fetch #(
  parameter rv_pkg::xlen_t RESET_PC = '0
) (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::insn_t     insn_i,
  input  rv_pkg::redirect_t redirect_i,
  output rv_pkg::xlen_t     pc_o,
  output rv_pkg::fd_t       fd_o
);

  rv_pkg::xlen_t pc_q;
  rv_pkg::fd_t   fd_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= RESET_PC;
    end else if (redirect_i.taken) begin
      pc_q <= redirect_i.target;
    end else begin
      pc_q <= pc_q + 32'd4;
    end
  end

  // Word in flight from imem dies on a redirect
  always_ff @(posedge clk) begin
    if (rst) begin
      fd_q.pc     <= '0;
      fd_q.insn   <= '0;
      fd_q.status <= rv_pkg::CYCLE_RESET;
    end else if (redirect_i.taken) begin
      fd_q.pc     <= '0;
      fd_q.insn   <= '0;
      fd_q.status <= rv_pkg::CYCLE_TAKEN_BRANCH;
    end else begin
      fd_q.pc     <= pc_q;
      fd_q.insn   <= insn_i;
      fd_q.status <= rv_pkg::CYCLE_NO_STALL;
    end
  end

  assign pc_o = pc_q;
  assign fd_o = fd_q;

  // B offsets only guarantee halfword alignment of a target
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc_q[1:0] == 2'b00);

endmodule

// ==== verilog/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  logic             we_i,
  input  rv_pkg::reg_idx_t waddr_i,
  input  rv_pkg::xlen_t    wdata_i,
  input  rv_pkg::reg_idx_t raddr1_i,
  input  rv_pkg::reg_idx_t raddr2_i,
  output rv_pkg::xlen_t    rdata1_o,
  output rv_pkg::xlen_t    rdata2_o
);

  rv_pkg::xlen_t regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Combinational reads with x0 hardwired to zero
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== common/rv_pkg.sv ====
package rv_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] insn_t;
  typedef logic [4:0]  reg_idx_t;

  // Major opcodes of the supported subset
  localparam logic [6:0] OP_REG_IMM = 7'b0010011;
  localparam logic [6:0] OP_REG_REG = 7'b0110011;
  localparam logic [6:0] OP_LUI     = 7'b0110111;
  localparam logic [6:0] OP_BRANCH  = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM  = 7'b1110011;

  // Class of every cycle seen in writeback
  typedef enum logic [1:0] {
    CYCLE_INVALID      = 2'd0,
    CYCLE_RESET        = 2'd1,
    CYCLE_NO_STALL     = 2'd2,
    CYCLE_TAKEN_BRANCH = 2'd3
  } cycle_status_e;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, LUI
  } alu_op_e;

  // Same encoding as funct3 of the branch
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } br_op_e;

  typedef struct packed {
    xlen_t         pc;
    insn_t         insn;
    cycle_status_e status;
  } fd_t;

  typedef struct packed {
    xlen_t         pc;
    insn_t         insn;
    reg_idx_t      rs1;
    reg_idx_t      rs2;
    reg_idx_t      rd;
    xlen_t         rs1_val;
    xlen_t         rs2_val;
    xlen_t         imm;
    logic          use_imm;
    alu_op_e       alu_op;
    logic          is_branch;
    br_op_e        br_op;
    logic          writes_rd;
    logic          is_ecall;
    cycle_status_e status;
  } dx_t;

  // Memory and writeback payload, also the retirement record
  typedef struct packed {
    xlen_t         pc;
    insn_t         insn;
    reg_idx_t      rd;
    xlen_t         wdata;
    logic          we;
    logic          halt;
    cycle_status_e status;
  } result_t;

  typedef struct packed {
    logic  taken;
    xlen_t target;
  } redirect_t;

  // A producer forwards only when it writes a nonzero destination
  function automatic xlen_t bypass(result_t src, reg_idx_t idx, xlen_t val);
    if (src.we && src.rd != '0 && src.rd == idx) begin
      return src.wdata;
    end
    return val;
  endfunction

endpackage
